// ==== rv_core_defines.svh ====
`ifndef RV_CORE_DEFINES_SVH
`define RV_CORE_DEFINES_SVH

// Data and address width
`define RV_XLEN            32
// Architectural integer registers
`define RV_NREGS           32
// First fetch address out of reset
`define RV_RESET_VECTOR    32'h8000_0000

// Major opcodes, instr[6:0]
`define RV_OPC_LUI         7'b0110111
`define RV_OPC_AUIPC       7'b0010111
`define RV_OPC_JAL         7'b1101111
`define RV_OPC_JALR        7'b1100111
`define RV_OPC_BRANCH      7'b1100011
`define RV_OPC_LOAD        7'b0000011
`define RV_OPC_STORE       7'b0100011
`define RV_OPC_OP_IMM      7'b0010011
`define RV_OPC_OP          7'b0110011

// Arithmetic funct3 groups, instr[14:12]
`define RV_F3_ADD          3'b000
`define RV_F3_SLL          3'b001
`define RV_F3_SLT          3'b010
`define RV_F3_SLTU         3'b011
`define RV_F3_XOR          3'b100
`define RV_F3_SR           3'b101
`define RV_F3_OR           3'b110
`define RV_F3_AND          3'b111

`endif

// ==== rv_core_pkg.sv ====
`default_nettype none

`include "rv_core_defines.svh"

package rv_core_pkg;

	// Data, address and instruction words
	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [31:0] instr_t;

	// Register index and shift count
	typedef logic [4:0] reg_addr_t;
	typedef logic [4:0] shamt_t;

	// One bit per byte lane of the data bus
	typedef logic [3:0] strb_t;

	typedef enum logic [2:0] {
		ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND, ALU_SLL, ALU_SRL, ALU_SRA
	} alu_op_t;

	typedef enum logic [1:0] {CMP_EQ, CMP_LT, CMP_LTU} cmp_op_t;

	// Operand sources
	typedef enum logic [1:0] {OPA_REG, OPA_PC, OPA_ZERO} opnd_a_t;
	typedef enum logic {OPB_REG, OPB_IMM} opnd_b_t;

	// Register write-back source
	typedef enum logic [2:0] {WB_ALU, WB_CMP, WB_LINK, WB_LOAD, WB_SHIFT} wb_sel_t;

	// Core sequencing states
	typedef enum logic [2:0] {
		ST_FETCH, ST_DECODE, ST_SHIFT, ST_EXECUTE, ST_MEM
	} core_state_t;

endpackage

`default_nettype wire

// ==== exec_if.sv ====
`timescale 1ns/100ps
`default_nettype none

interface exec_if;
	import rv_core_pkg::*;

	// Driven by the control FSM
	instr_t instr;
	word_t pc;
	alu_op_t alu_op;
	cmp_op_t cmp_op;
	opnd_a_t a_sel;
	opnd_b_t b_sel;
	wb_sel_t wb_sel;
	logic shift_load;
	logic shift_step;
	logic mem_start;

	// Driven back by the datapath
	word_t imm;
	word_t alu_out;
	logic cmp_true;
	word_t load_data;
	logic mem_done;

	modport control (
		output instr, pc, alu_op, cmp_op, a_sel, b_sel, wb_sel,
		output shift_load, shift_step, mem_start,
		input alu_out, cmp_true, mem_done
	);

	modport exec (
		input instr, pc, alu_op, cmp_op, a_sel, b_sel, wb_sel,
		input shift_load, shift_step, load_data,
		output imm, alu_out, cmp_true
	);

	modport lsu (
		input instr, alu_out, mem_start,
		output load_data, mem_done
	);

endinterface

`default_nettype wire

// ==== core_control.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_defines.svh"

module core_control (
	input logic clock,
	input logic reset,
	exec_if.control ctrl,
	output rv_core_pkg::word_t iaddr,
	input rv_core_pkg::instr_t idata,
	output logic ivalid,
	input logic iready,
	output rv_core_pkg::reg_addr_t ra_addr,
	output rv_core_pkg::reg_addr_t rb_addr,
	input rv_core_pkg::word_t rb_data,
	output rv_core_pkg::reg_addr_t rd_addr,
	output logic rd_wen
);
	import rv_core_pkg::*;

	core_state_t state;
	instr_t instr_q;
	word_t pc_q;
	word_t pc_plus4;
	word_t pc_next;
	shamt_t shift_cnt;
	shamt_t shift_amount;
	logic fetch_en;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic op_lui, op_auipc, op_jal, op_jalr, op_branch;
	logic op_load, op_store, op_imm, op_reg;
	logic op_shift;
	logic writes_rd;
	logic branch_taken;

	assign opcode = instr_q[6:0];
	assign funct3 = instr_q[14:12];

	assign op_lui = (opcode == `RV_OPC_LUI);
	assign op_auipc = (opcode == `RV_OPC_AUIPC);
	assign op_jal = (opcode == `RV_OPC_JAL);
	assign op_jalr = (opcode == `RV_OPC_JALR);
	assign op_branch = (opcode == `RV_OPC_BRANCH);
	assign op_load = (opcode == `RV_OPC_LOAD);
	assign op_store = (opcode == `RV_OPC_STORE);
	assign op_imm = (opcode == `RV_OPC_OP_IMM);
	assign op_reg = (opcode == `RV_OPC_OP);
	assign op_shift = (op_imm || op_reg) && (funct3 == `RV_F3_SLL || funct3 == `RV_F3_SR);
	// Unknown opcodes fall through as no-ops
	assign writes_rd = op_lui || op_auipc || op_jal || op_jalr || op_imm || op_reg;

	// Shift count from the immediate field or from rs2
	assign shift_amount = op_reg ? rb_data[4:0] : instr_q[24:20];

	// funct3[0] flips BEQ/BLT/BLTU into BNE/BGE/BGEU
	assign branch_taken = op_branch && (ctrl.cmp_true ^ funct3[0]);
	assign pc_plus4 = pc_q + 32'd4;
	assign pc_next = (op_jal || op_jalr || branch_taken) ? {ctrl.alu_out[31:1], 1'b0} : pc_plus4;

	// Fetch request is held steady until iready
	assign iaddr = pc_q;
	assign ivalid = fetch_en && (state == ST_FETCH);

	// Register indices sit at fixed positions
	assign ra_addr = instr_q[19:15];
	assign rb_addr = instr_q[24:20];
	assign rd_addr = instr_q[11:7];
	assign rd_wen = (state == ST_EXECUTE && writes_rd)
		|| (state == ST_MEM && op_load && ctrl.mem_done);

	assign ctrl.instr = instr_q;
	assign ctrl.pc = pc_q;
	assign ctrl.shift_load = (state == ST_DECODE) && op_shift;
	assign ctrl.shift_step = (state == ST_SHIFT);
	assign ctrl.mem_start = (state == ST_MEM);

	always_comb begin
		ctrl.alu_op = ALU_ADD;
		ctrl.cmp_op = CMP_EQ;
		ctrl.a_sel = OPA_REG;
		ctrl.b_sel = OPB_IMM;
		ctrl.wb_sel = WB_ALU;
		if (op_lui) begin
			ctrl.a_sel = OPA_ZERO;
		end else if (op_auipc || op_jal || op_branch) begin
			// PC-relative target or result
			ctrl.a_sel = OPA_PC;
		end
		if (op_reg) begin
			ctrl.b_sel = OPB_REG;
		end
		if (op_imm || op_reg) begin
			ctrl.cmp_op = (funct3 == `RV_F3_SLT) ? CMP_LT : CMP_LTU;
			case (funct3)
				`RV_F3_ADD: ctrl.alu_op = (op_reg && instr_q[30]) ? ALU_SUB : ALU_ADD;
				`RV_F3_SLL: ctrl.alu_op = ALU_SLL;
				`RV_F3_SR: ctrl.alu_op = instr_q[30] ? ALU_SRA : ALU_SRL;
				`RV_F3_XOR: ctrl.alu_op = ALU_XOR;
				`RV_F3_OR: ctrl.alu_op = ALU_OR;
				`RV_F3_AND: ctrl.alu_op = ALU_AND;
				default: ctrl.alu_op = ALU_ADD;
			endcase
			if (op_shift) begin
				ctrl.wb_sel = WB_SHIFT;
			end else if (funct3 == `RV_F3_SLT || funct3 == `RV_F3_SLTU) begin
				ctrl.wb_sel = WB_CMP;
			end
		end else if (op_branch) begin
			case (funct3[2:1])
				2'b10: ctrl.cmp_op = CMP_LT;
				2'b11: ctrl.cmp_op = CMP_LTU;
				default: ctrl.cmp_op = CMP_EQ;
			endcase
		end else if (op_jal || op_jalr) begin
			ctrl.wb_sel = WB_LINK;
		end else if (op_load) begin
			ctrl.wb_sel = WB_LOAD;
		end
	end

	// Instruction word, captured on the fetch transfer
	always_ff @(posedge clock) begin
		if (ivalid && iready) begin
			instr_q <= idata;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= ST_FETCH;
			pc_q <= `RV_RESET_VECTOR;
			shift_cnt <= '0;
			fetch_en <= 1'b0;
		end else begin
			fetch_en <= 1'b1;
			case (state)
				ST_FETCH: begin
					if (ivalid && iready) begin
						state <= ST_DECODE;
					end
				end
				ST_DECODE: begin
					// Zero-length shifts skip straight to execute
					shift_cnt <= shift_amount;
					if (op_shift && shift_amount != '0) begin
						state <= ST_SHIFT;
					end else begin
						state <= ST_EXECUTE;
					end
				end
				ST_SHIFT: begin
					shift_cnt <= shift_cnt - 5'd1;
					if (shift_cnt == 5'd1) begin
						state <= ST_EXECUTE;
					end
				end
				ST_EXECUTE: begin
					if (op_load || op_store) begin
						state <= ST_MEM;
					end else begin
						pc_q <= pc_next;
						state <= ST_FETCH;
					end
				end
				ST_MEM: begin
					if (ctrl.mem_done) begin
						pc_q <= pc_next;
						state <= ST_FETCH;
					end
				end
				default: state <= ST_FETCH;
			endcase
		end
	end

	// Instruction and data bus never requested in the same cycle
	assert property (@(posedge clock) disable iff (reset) !(ivalid && ctrl.mem_start))
		else $error("ivalid and mem_start both high");

	assert property (@(posedge clock) disable iff (reset)
		state inside {ST_FETCH, ST_DECODE, ST_SHIFT, ST_EXECUTE, ST_MEM})
		else $error("state outside encoding");

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_defines.svh"

module reg_file (
	input logic clock,
	input rv_core_pkg::reg_addr_t ra_addr,
	input rv_core_pkg::reg_addr_t rb_addr,
	output rv_core_pkg::word_t ra_data,
	output rv_core_pkg::word_t rb_data,
	input rv_core_pkg::reg_addr_t rd_addr,
	input rv_core_pkg::word_t rd_data,
	input logic rd_wen
);
	import rv_core_pkg::*;

	// Entry 0 is never written
	word_t regs [0:`RV_NREGS-1];

	// Asynchronous reads, x0 forced to zero
	assign ra_data = (ra_addr == '0) ? '0 : regs[ra_addr];
	assign rb_data = (rb_addr == '0) ? '0 : regs[rb_addr];

	always_ff @(posedge clock) begin
		if (rd_wen && rd_addr != '0) begin
			regs[rd_addr] <= rd_data;
		end
	end

endmodule

`default_nettype wire

// ==== imm_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_defines.svh"

module imm_gen (
	exec_if.exec dp
);
	import rv_core_pkg::*;

	instr_t ir;

	assign ir = dp.instr;

	always_comb begin
		case (ir[6:0])
			// I-type
			`RV_OPC_OP_IMM, `RV_OPC_LOAD, `RV_OPC_JALR: begin
				dp.imm = {{20{ir[31]}}, ir[31:20]};
			end
			// S-type, split field
			`RV_OPC_STORE: begin
				dp.imm = {{20{ir[31]}}, ir[31:25], ir[11:7]};
			end
			// B-type, halfword offset
			`RV_OPC_BRANCH: begin
				dp.imm = {{19{ir[31]}}, ir[31], ir[7], ir[30:25], ir[11:8], 1'b0};
			end
			// U-type upper 20 bits
			`RV_OPC_LUI, `RV_OPC_AUIPC: begin
				dp.imm = {ir[31:12], 12'h000};
			end
			// J-type
			`RV_OPC_JAL: begin
				dp.imm = {{11{ir[31]}}, ir[31], ir[19:12], ir[20], ir[30:21], 1'b0};
			end
			// R-type and anything else
			default: begin
				dp.imm = '0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== execute_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
	input logic clock,
	exec_if.exec dp,
	input rv_core_pkg::word_t ra_data,
	input rv_core_pkg::word_t rb_data,
	output rv_core_pkg::word_t rd_data
);
	import rv_core_pkg::*;

	word_t op_a;
	word_t op_b;
	word_t cmp_b;
	word_t alu_res;
	word_t shift_acc;
	logic cmp_res;

	always_comb begin
		case (dp.a_sel)
			OPA_PC: op_a = dp.pc;
			OPA_ZERO: op_a = '0;
			default: op_a = ra_data;
		endcase
	end

	assign op_b = (dp.b_sel == OPB_REG) ? rb_data : dp.imm;

	// Branches use the ALU for the target, so the comparator takes rs2 then
	assign cmp_b = (dp.a_sel == OPA_REG) ? op_b : rb_data;

	always_comb begin
		case (dp.alu_op)
			ALU_SUB: alu_res = op_a - op_b;
			ALU_XOR: alu_res = op_a ^ op_b;
			ALU_OR: alu_res = op_a | op_b;
			ALU_AND: alu_res = op_a & op_b;
			default: alu_res = op_a + op_b;
		endcase
	end

	always_comb begin
		case (dp.cmp_op)
			CMP_LT: cmp_res = ($signed(ra_data) < $signed(cmp_b));
			CMP_LTU: cmp_res = (ra_data < cmp_b);
			default: cmp_res = (ra_data == cmp_b);
		endcase
	end

	assign dp.alu_out = alu_res;
	assign dp.cmp_true = cmp_res;

	// Shift accumulator, one bit per step
	always_ff @(posedge clock) begin
		if (dp.shift_load) begin
			shift_acc <= ra_data;
		end else if (dp.shift_step) begin
			case (dp.alu_op)
				ALU_SLL: shift_acc <= {shift_acc[30:0], 1'b0};
				ALU_SRA: shift_acc <= {shift_acc[31], shift_acc[31:1]};
				default: shift_acc <= {1'b0, shift_acc[31:1]};
			endcase
		end
	end

	// Write-back source
	always_comb begin
		case (dp.wb_sel)
			WB_CMP: rd_data = {31'd0, cmp_res};
			WB_LINK: rd_data = dp.pc + 32'd4;
			WB_LOAD: rd_data = dp.load_data;
			WB_SHIFT: rd_data = shift_acc;
			default: rd_data = alu_res;
		endcase
	end

	assert property (@(posedge clock) !(dp.shift_load && dp.shift_step))
		else $error("shift_load and shift_step both high");

endmodule

`default_nettype wire

// ==== load_store_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_defines.svh"

module load_store_unit (
	exec_if.lsu dp,
	input rv_core_pkg::word_t rb_data,
	output rv_core_pkg::word_t daddr,
	output rv_core_pkg::word_t dwdata,
	input rv_core_pkg::word_t drdata,
	output rv_core_pkg::strb_t dstrb,
	output logic dwrite,
	output logic dvalid,
	input logic dready
);
	import rv_core_pkg::*;

	logic [2:0] funct3;
	logic is_store;
	logic [7:0] ld_byte;
	logic [15:0] ld_half;

	assign funct3 = dp.instr[14:12];
	assign is_store = (dp.instr[6:0] == `RV_OPC_STORE);

	// Request held for the whole MEM state
	assign daddr = dp.alu_out;
	assign dvalid = dp.mem_start;
	assign dwrite = dp.mem_start && is_store;
	assign dp.mem_done = dvalid && dready;

	// funct3[1:0] gives the access size
	always_comb begin
		case (funct3[1:0])
			2'b00: begin
				dstrb = 4'b0001 << daddr[1:0];
				dwdata = {4{rb_data[7:0]}};
			end
			2'b01: begin
				dstrb = daddr[1] ? 4'b1100 : 4'b0011;
				dwdata = {2{rb_data[15:0]}};
			end
			default: begin
				dstrb = 4'b1111;
				dwdata = rb_data;
			end
		endcase
	end

	// Addressed lane of the read word
	assign ld_byte = drdata[8*daddr[1:0] +: 8];
	assign ld_half = daddr[1] ? drdata[31:16] : drdata[15:0];

	// funct3[2] selects zero extension
	always_comb begin
		case (funct3[1:0])
			2'b00: dp.load_data = {{24{ld_byte[7] & ~funct3[2]}}, ld_byte};
			2'b01: dp.load_data = {{16{ld_half[15] & ~funct3[2]}}, ld_half};
			default: dp.load_data = drdata;
		endcase
	end

endmodule

`default_nettype wire

// ==== rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

module rv_core (
	input logic clock,
	input logic reset,
	output rv_core_pkg::word_t iaddr,
	input rv_core_pkg::instr_t idata,
	output logic ivalid,
	input logic iready,
	output rv_core_pkg::word_t daddr,
	output rv_core_pkg::word_t dwdata,
	input rv_core_pkg::word_t drdata,
	output rv_core_pkg::strb_t dstrb,
	output logic dwrite,
	output logic dvalid,
	input logic dready
);
	import rv_core_pkg::*;

	reg_addr_t ra_addr;
	reg_addr_t rb_addr;
	reg_addr_t rd_addr;
	word_t ra_data;
	word_t rb_data;
	word_t rd_data;
	logic rd_wen;

	// Control to datapath bundle
	exec_if u_if ();

	core_control u_ctrl (
		.clock   (clock),
		.reset   (reset),
		.ctrl    (u_if.control),
		.iaddr   (iaddr),
		.idata   (idata),
		.ivalid  (ivalid),
		.iready  (iready),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.rb_data (rb_data),
		.rd_addr (rd_addr),
		.rd_wen  (rd_wen)
	);

	reg_file u_regs (
		.clock   (clock),
		.ra_addr (ra_addr),
		.rb_addr (rb_addr),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.rd_wen  (rd_wen)
	);

	imm_gen u_imm (
		.dp (u_if.exec)
	);

	execute_unit u_exec (
		.clock   (clock),
		.dp      (u_if.exec),
		.ra_data (ra_data),
		.rb_data (rb_data),
		.rd_data (rd_data)
	);

	// Store data comes straight from rs2
	load_store_unit u_lsu (
		.dp      (u_if.lsu),
		.rb_data (rb_data),
		.daddr   (daddr),
		.dwdata  (dwdata),
		.drdata  (drdata),
		.dstrb   (dstrb),
		.dwrite  (dwrite),
		.dvalid  (dvalid),
		.dready  (dready)
	);

endmodule

`default_nettype wire

// ==== tb_memory.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_defines.svh"

module tb_memory (
	input logic clock,
	input logic stall,
	input logic fill,
	input logic load_en,
	input logic [7:0] load_idx,
	input rv_core_pkg::word_t load_data,
	input rv_core_pkg::word_t iaddr,
	output rv_core_pkg::instr_t idata,
	input logic ivalid,
	output logic iready,
	input rv_core_pkg::word_t daddr,
	input rv_core_pkg::word_t dwdata,
	output rv_core_pkg::word_t drdata,
	input rv_core_pkg::strb_t dstrb,
	input logic dwrite,
	input logic dvalid,
	output logic dready
);
	import rv_core_pkg::*;

	localparam int DEPTH = 256;

	// 1 KB image from the reset vector up
	word_t words [0:DEPTH-1];

	// Store transfers in arrival order
	word_t rec_addr [0:63];
	word_t rec_data [0:63];
	strb_t rec_strb [0:63];
	int rec_count = 0;

	int seed = 32'h5362;
	logic [31:0] roll;
	logic iready_r = 1'b1;
	logic dready_r = 1'b1;

	assign iready = iready_r;
	assign dready = dready_r;

	// Read data is zero while no request is up
	assign idata = (ivalid === 1'b1) ? words[iaddr[9:2]] : '0;
	assign drdata = (dvalid === 1'b1) ? words[daddr[9:2]] : '0;

	always @(posedge clock) begin
		if (fill) begin
			// Pattern tied to each word's own address
			for (int i = 0; i < DEPTH; i++) begin
				words[i] <= (`RV_RESET_VECTOR + word_t'(i * 4)) ^ 32'h5a5a_5a5a;
			end
			rec_count <= 0;
		end else if (load_en) begin
			words[load_idx] <= load_data;
		end else if (dvalid && dready && dwrite) begin
			for (int b = 0; b < 4; b++) begin
				if (dstrb[b]) begin
					words[daddr[9:2]][8*b +: 8] <= dwdata[8*b +: 8];
				end
			end
			if (rec_count < 64) begin
				rec_addr[rec_count] <= daddr;
				rec_data[rec_count] <= dwdata;
				rec_strb[rec_count] <= dstrb;
				rec_count <= rec_count + 1;
			end
		end
	end

	// Ready lines low about one cycle in four when stalling
	always @(posedge clock) begin
		#2;
		roll = $random(seed);
		if (stall) begin
			iready_r = (roll[1:0] != 2'b00);
			dready_r = (roll[3:2] != 2'b00);
		end else begin
			iready_r = 1'b1;
			dready_r = 1'b1;
		end
	end

endmodule

`default_nettype wire

// ==== tb_rv_core.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "rv_core_defines.svh"

module tb_rv_core;
	import rv_core_pkg::*;

	localparam int PERIOD = 40;
	localparam int TIMEOUT = 5000;
	localparam word_t DATA_BASE = `RV_RESET_VECTOR + 32'h200;
	// Known word at 0x8000_0300 for the load test
	localparam word_t LOAD_WORD = 32'hf001_7f82;

	logic clock;
	logic reset;
	word_t iaddr;
	instr_t idata;
	logic ivalid;
	logic iready;
	word_t daddr;
	word_t dwdata;
	word_t drdata;
	strb_t dstrb;
	logic dwrite;
	logic dvalid;
	logic dready;
	logic stall;
	logic fill;
	logic load_en;
	logic [7:0] load_idx;
	word_t load_data;

	int errors;
	int timeouts;
	instr_t prog [$];
	word_t exp_addr [$];
	word_t exp_data [$];
	strb_t exp_strb [$];
	word_t unstalled [$];

	rv_core uut (
		.clock  (clock),
		.reset  (reset),
		.iaddr  (iaddr),
		.idata  (idata),
		.ivalid (ivalid),
		.iready (iready),
		.daddr  (daddr),
		.dwdata (dwdata),
		.drdata (drdata),
		.dstrb  (dstrb),
		.dwrite (dwrite),
		.dvalid (dvalid),
		.dready (dready)
	);

	tb_memory u_mem (
		.clock     (clock),
		.stall     (stall),
		.fill      (fill),
		.load_en   (load_en),
		.load_idx  (load_idx),
		.load_data (load_data),
		.iaddr     (iaddr),
		.idata     (idata),
		.ivalid    (ivalid),
		.iready    (iready),
		.daddr     (daddr),
		.dwdata    (dwdata),
		.drdata    (drdata),
		.dstrb     (dstrb),
		.dwrite    (dwrite),
		.dvalid    (dvalid),
		.dready    (dready)
	);

	initial begin
		clock = 1'b0;
		forever #(PERIOD / 2) clock = ~clock;
	end

	// Instruction encoders per RV32I format
	function automatic instr_t enc_r(input int f7, input int rs2, input int rs1, input int f3,
			input int rd);
		return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], `RV_OPC_OP};
	endfunction

	function automatic instr_t enc_i(input int imm, input int rs1, input int f3, input int rd,
			input logic [6:0] opc);
		return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
	endfunction

	function automatic instr_t enc_s(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], `RV_OPC_STORE};
	endfunction

	function automatic instr_t enc_b(input int imm, input int rs2, input int rs1, input int f3);
		return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
			`RV_OPC_BRANCH};
	endfunction

	function automatic instr_t enc_u(input int imm, input int rd, input logic [6:0] opc);
		return {imm[19:0], rd[4:0], opc};
	endfunction

	function automatic instr_t enc_j(input int imm, input int rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], `RV_OPC_JAL};
	endfunction

	// Branch outcome straight from the ISA rules
	function automatic bit branch_taken(input int f3, input word_t a, input word_t b);
		case (f3)
			0: return a == b;
			1: return a != b;
			4: return $signed(a) < $signed(b);
			5: return $signed(a) >= $signed(b);
			6: return a < b;
			7: return a >= b;
			default: return 1'b0;
		endcase
	endfunction

	task automatic check_word(input string name, input word_t expected, input word_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %h, actual %h", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_strb(input string name, input strb_t expected, input strb_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %b, actual %b", name, expected, actual);
			errors++;
		end
	endtask

	task automatic check_state(input string name, input core_state_t expected,
			input core_state_t actual);
		if (actual !== expected) begin
			$display("Mismatch %s: expected %s, actual %s", name, expected.name(),
				actual.name());
			errors++;
		end
	endtask

	task automatic next_cycle();
		@(posedge clock);
		#2;
	endtask

	task automatic new_test();
		prog.delete();
		exp_addr.delete();
		exp_data.delete();
		exp_strb.delete();
	endtask

	task automatic emit(input instr_t w);
		prog.push_back(w);
	endtask

	task automatic expect_store(input word_t addr, input word_t data, input strb_t strb);
		exp_addr.push_back(addr);
		exp_data.push_back(data);
		exp_strb.push_back(strb);
	endtask

	// Op into x5, then SW x5 to the next result slot
	task automatic result_store(input instr_t op, input word_t expected);
		int k;
		k = exp_data.size();
		emit(op);
		emit(enc_s(k * 4, 5, 1, 2));
		expect_store(DATA_BASE + word_t'(k * 4), expected, 4'b1111);
	endtask

	function automatic word_t next_pc();
		return `RV_RESET_VECTOR + word_t'(prog.size() * 4);
	endfunction

	// x1 points at the result area
	task automatic emit_base();
		emit(enc_u(32'h80000, 1, `RV_OPC_LUI));
		emit(enc_i(32'h200, 1, 0, 1, `RV_OPC_OP_IMM));
	endtask

	// Load image under reset, then release the core
	task automatic start_program();
		reset = 1'b1;
		fill = 1'b1;
		next_cycle();
		fill = 1'b0;
		foreach (prog[i]) begin
			load_en = 1'b1;
			load_idx = i[7:0];
			load_data = prog[i];
			next_cycle();
		end
		load_idx = 8'd192;
		load_data = LOAD_WORD;
		next_cycle();
		load_en = 1'b0;
		repeat (5) begin
			next_cycle();
			if (ivalid !== 1'b0) begin
				$display("ivalid went high while reset was asserted");
				errors++;
			end
		end
		reset = 1'b0;
	endtask

	task automatic wait_and_check(input string name);
		int cycles;
		cycles = 0;
		while (u_mem.rec_count < exp_data.size() && cycles < TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			$display("%s: timed out waiting for %0d stores, only %0d seen", name,
				exp_data.size(), u_mem.rec_count);
			timeouts++;
		end
		// Room for a stray extra store to show up
		repeat (20) next_cycle();
		if (u_mem.rec_count != exp_data.size()) begin
			$display("%s: expected %0d stores but %0d were recorded", name,
				exp_data.size(), u_mem.rec_count);
			errors++;
		end
		for (int i = 0; i < exp_data.size() && i < u_mem.rec_count; i++) begin
			check_word($sformatf("%s addr %0d", name, i), exp_addr[i], u_mem.rec_addr[i]);
			check_word($sformatf("%s data %0d", name, i), exp_data[i], u_mem.rec_data[i]);
			check_strb($sformatf("%s strb %0d", name, i), exp_strb[i], u_mem.rec_strb[i]);
		end
	endtask

	task automatic test_reset();
		int cycles;
		new_test();
		emit(enc_j(0, 0));
		start_program();
		cycles = 0;
		while (ivalid !== 1'b1 && cycles < TIMEOUT) begin
			next_cycle();
			cycles++;
		end
		if (cycles >= TIMEOUT) begin
			$display("reset: ivalid never rose after reset was released");
			timeouts++;
		end else begin
			check_word("reset iaddr", `RV_RESET_VECTOR, iaddr);
			// Fetch transfer on the next edge, then one cycle each of decode and execute
			next_cycle();
			check_state("reset decode", ST_DECODE, uut.u_ctrl.state);
			next_cycle();
			check_state("reset execute", ST_EXECUTE, uut.u_ctrl.state);
			next_cycle();
			// Jump to itself brings the fetch back to the reset vector
			if (ivalid !== 1'b1) begin
				$display("reset: no new fetch request after the first instruction");
				errors++;
			end
			check_word("reset jump target", `RV_RESET_VECTOR, iaddr);
		end
	endtask

	task automatic test_arith(input string name, input logic with_stall);
		word_t pc;
		new_test();
		emit_base();
		// x2 = max int, x3 = min int, x4 = -1
		emit(enc_u(32'h80000, 2, `RV_OPC_LUI));
		emit(enc_i(-1, 2, 0, 2, `RV_OPC_OP_IMM));
		emit(enc_u(32'h80000, 3, `RV_OPC_LUI));
		emit(enc_i(-1, 0, 0, 4, `RV_OPC_OP_IMM));
		result_store(enc_i(1, 2, 0, 5, `RV_OPC_OP_IMM), 32'h8000_0000);
		result_store(enc_i(-2048, 3, 0, 5, `RV_OPC_OP_IMM), 32'h7fff_f800);
		result_store(enc_r(0, 4, 2, 0, 5), 32'h7fff_fffe);
		result_store(enc_r(32, 2, 3, 0, 5), 32'h0000_0001);
		result_store(enc_r(0, 4, 2, 4, 5), 32'h8000_0000);
		result_store(enc_r(0, 2, 3, 6, 5), 32'hffff_ffff);
		result_store(enc_r(0, 2, 4, 7, 5), 32'h7fff_ffff);
		result_store(enc_r(0, 2, 3, 2, 5), 32'h0000_0001);
		result_store(enc_r(0, 2, 3, 3, 5), 32'h0000_0000);
		result_store(enc_r(0, 3, 2, 3, 5), 32'h0000_0001);
		result_store(enc_i(0, 4, 2, 5, `RV_OPC_OP_IMM), 32'h0000_0001);
		result_store(enc_i(1, 4, 3, 5, `RV_OPC_OP_IMM), 32'h0000_0000);
		result_store(enc_i(-1, 2, 4, 5, `RV_OPC_OP_IMM), 32'h8000_0000);
		result_store(enc_i(32'h555, 3, 6, 5, `RV_OPC_OP_IMM), 32'h8000_0555);
		result_store(enc_i(32'h7f0, 4, 7, 5, `RV_OPC_OP_IMM), 32'h0000_07f0);
		result_store(enc_u(32'habcde, 5, `RV_OPC_LUI), 32'habcd_e000);
		pc = next_pc();
		result_store(enc_u(1, 5, `RV_OPC_AUIPC), pc + 32'h1000);
		emit(enc_j(0, 0));
		stall = with_stall;
		start_program();
		wait_and_check(name);
		stall = 1'b0;
		if (!with_stall) begin
			unstalled.delete();
			for (int i = 0; i < u_mem.rec_count; i++) begin
				unstalled.push_back(u_mem.rec_data[i]);
			end
		end else begin
			foreach (unstalled[i]) begin
				check_word($sformatf("%s vs unstalled %0d", name, i), unstalled[i],
					u_mem.rec_data[i]);
			end
		end
	endtask

	task automatic test_shifts();
		int counts [4];
		word_t v;
		int n;
		counts = '{0, 1, 13, 31};
		v = 32'h8765_4321;
		new_test();
		emit_base();
		emit(enc_u(32'h87654, 2, `RV_OPC_LUI));
		emit(enc_i(32'h321, 2, 0, 2, `RV_OPC_OP_IMM));
		foreach (counts[c]) begin
			n = counts[c];
			result_store(enc_i(n, 2, 1, 5, `RV_OPC_OP_IMM), v << n);
			result_store(enc_i(n, 2, 5, 5, `RV_OPC_OP_IMM), v >> n);
			result_store(enc_i(32'h400 | n, 2, 5, 5, `RV_OPC_OP_IMM), word_t'($signed(v) >>> n));
			// Register forms take the count from x6
			emit(enc_i(n, 0, 0, 6, `RV_OPC_OP_IMM));
			result_store(enc_r(0, 6, 2, 1, 5), v << n);
			result_store(enc_r(0, 6, 2, 5, 5), v >> n);
			result_store(enc_r(32, 6, 2, 5, 5), word_t'($signed(v) >>> n));
		end
		emit(enc_j(0, 0));
		start_program();
		wait_and_check("shifts");
	endtask

	task automatic test_load_store();
		new_test();
		emit_base();
		emit(enc_u(32'ha5b6c, 2, `RV_OPC_LUI));
		emit(enc_i(32'h7d8, 2, 0, 2, `RV_OPC_OP_IMM));
		emit(enc_u(32'h80000, 7, `RV_OPC_LUI));
		emit(enc_i(32'h300, 7, 0, 7, `RV_OPC_OP_IMM));
		for (int o = 0; o < 4; o++) begin
			emit(enc_s(64 + o, 2, 1, 0));
			expect_store(DATA_BASE + word_t'(64 + o), 32'hd8d8_d8d8, strb_t'(4'b0001 << o));
		end
		emit(enc_s(68, 2, 1, 1));
		expect_store(DATA_BASE + 32'd68, 32'hc7d8_c7d8, 4'b0011);
		emit(enc_s(70, 2, 1, 1));
		expect_store(DATA_BASE + 32'd70, 32'hc7d8_c7d8, 4'b1100);
		// Bytes of the known word are 82 7f 01 f0
		result_store(enc_i(0, 7, 0, 5, `RV_OPC_LOAD), 32'hffff_ff82);
		result_store(enc_i(0, 7, 4, 5, `RV_OPC_LOAD), 32'h0000_0082);
		result_store(enc_i(1, 7, 0, 5, `RV_OPC_LOAD), 32'h0000_007f);
		result_store(enc_i(3, 7, 0, 5, `RV_OPC_LOAD), 32'hffff_fff0);
		result_store(enc_i(3, 7, 4, 5, `RV_OPC_LOAD), 32'h0000_00f0);
		result_store(enc_i(0, 7, 1, 5, `RV_OPC_LOAD), 32'h0000_7f82);
		result_store(enc_i(2, 7, 1, 5, `RV_OPC_LOAD), 32'hffff_f001);
		result_store(enc_i(2, 7, 5, 5, `RV_OPC_LOAD), 32'h0000_f001);
		result_store(enc_i(0, 7, 2, 5, `RV_OPC_LOAD), LOAD_WORD);
		emit(enc_j(0, 0));
		start_program();
		wait_and_check("load_store");
	endtask

	// Marker k when taken, k + 0x100 when the branch falls through
	task automatic branch_case(input int f3, input int rs1, input word_t va, input int rs2,
			input word_t vb, input int marker);
		int k;
		k = exp_data.size();
		emit(enc_i(marker, 0, 0, 5, `RV_OPC_OP_IMM));
		emit(enc_b(8, rs2, rs1, f3));
		emit(enc_i(32'h100, 5, 0, 5, `RV_OPC_OP_IMM));
		emit(enc_s(k * 4, 5, 1, 2));
		expect_store(DATA_BASE + word_t'(k * 4),
			branch_taken(f3, va, vb) ? word_t'(marker) : word_t'(marker + 32'h100), 4'b1111);
	endtask

	task automatic test_control();
		word_t v2;
		word_t v3;
		word_t pc;
		int k;
		v2 = 32'd5;
		v3 = 32'hffff_fffd;
		new_test();
		emit_base();
		emit(enc_i(5, 0, 0, 2, `RV_OPC_OP_IMM));
		emit(enc_i(-3, 0, 0, 3, `RV_OPC_OP_IMM));
		emit(enc_i(5, 0, 0, 4, `RV_OPC_OP_IMM));
		branch_case(0, 2, v2, 4, v2, 1);
		branch_case(0, 2, v2, 3, v3, 2);
		branch_case(1, 2, v2, 3, v3, 3);
		branch_case(1, 2, v2, 4, v2, 4);
		branch_case(4, 3, v3, 2, v2, 5);
		branch_case(4, 2, v2, 3, v3, 6);
		branch_case(5, 2, v2, 3, v3, 7);
		branch_case(5, 3, v3, 2, v2, 8);
		branch_case(6, 2, v2, 3, v3, 9);
		branch_case(6, 3, v3, 2, v2, 10);
		branch_case(7, 3, v3, 2, v2, 11);
		branch_case(7, 2, v2, 3, v3, 12);
		// JAL over a zero store, then store the link
		k = exp_data.size();
		pc = next_pc();
		emit(enc_j(8, 6));
		emit(enc_s(k * 4, 0, 1, 2));
		emit(enc_s(k * 4, 6, 1, 2));
		expect_store(DATA_BASE + word_t'(k * 4), pc + 32'd4, 4'b1111);
		// JALR with an odd offset, bit 0 of the target dropped
		k = exp_data.size();
		pc = next_pc();
		emit(enc_u(0, 7, `RV_OPC_AUIPC));
		emit(enc_i(13, 7, 0, 8, `RV_OPC_JALR));
		emit(enc_s(k * 4, 0, 1, 2));
		// Landing PC captured in x9
		emit(enc_u(0, 9, `RV_OPC_AUIPC));
		emit(enc_s(k * 4, 8, 1, 2));
		emit(enc_s(k * 4 + 4, 9, 1, 2));
		expect_store(DATA_BASE + word_t'(k * 4), pc + 32'd8, 4'b1111);
		expect_store(DATA_BASE + word_t'(k * 4 + 4), pc + 32'd12, 4'b1111);
		emit(enc_j(0, 0));
		start_program();
		wait_and_check("control");
	endtask

	initial begin
		errors = 0;
		timeouts = 0;
		reset = 1'b1;
		stall = 1'b0;
		fill = 1'b0;
		load_en = 1'b0;
		load_idx = '0;
		load_data = '0;
		test_reset();
		test_arith("arith", 1'b0);
		test_shifts();
		test_load_store();
		test_control();
		test_arith("backpressure", 1'b1);
		$display("Errors: %0d check failures, %0d timeouts", errors, timeouts);
		if (errors == 0 && timeouts == 0) begin
			$display("Result: PASSED");
		end else begin
			$display("Result: FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+.
rv_core_pkg.sv
exec_if.sv
core_control.sv
reg_file.sv
imm_gen.sv
execute_unit.sv
load_store_unit.sv
rv_core.sv
tb_memory.sv
tb_rv_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_rv_core
OBJ_DIR ?= obj_dir
FILELIST ?= sources.f
VFLAGS ?= --binary --timing --assert -j 0
PASS_TEXT ?= Result: PASSED

SRCS := $(wildcard *.sv *.svh)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
